/* Bender.yml */
package:
  name: dual_backend

export_include_dirs:
  - source

sources:
  - files:
      - source/la32_isa_pkg.sv
      - source/issue_pkg.sv
      - source/operand_forward.sv
      - source/alu_pair.sv
      - source/branch_resolve.sv
      - source/mem_port.sv
      - source/stage_regs.sv
      - source/ex_mem_wb.sv
  - target: test
    files:
      - verif/ex_mem_wb_assertions.sv
      - verif/tb_ex_mem_wb.sv

/* dual_backend.f */
+incdir+source
source/la32_isa_pkg.sv
source/issue_pkg.sv
source/operand_forward.sv
source/alu_pair.sv
source/branch_resolve.sv
source/mem_port.sv
source/stage_regs.sv
source/ex_mem_wb.sv
verif/ex_mem_wb_assertions.sv
verif/tb_ex_mem_wb.sv

/* source/alu_pair.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module alu_pair import la32_isa_pkg::*, issue_pkg::*; (
  input  logic [`XLEN-1:0] ex_pc_a,
  input  logic [`XLEN-1:0] ex_pc_b,
  input  logic [`XLEN-1:0] fwd_a1,
  input  logic [`XLEN-1:0] fwd_a2,
  input  logic [`XLEN-1:0] fwd_b1,
  input  logic [`XLEN-1:0] fwd_b2,
  input  logic [`XLEN-1:0] ex_imm_a,
  input  logic [`XLEN-1:0] ex_imm_b,
  input  src_sel_e         ex_src_sel_a1,
  input  src_sel_e         ex_src_sel_a2,
  input  src_sel_e         ex_src_sel_b1,
  input  src_sel_e         ex_src_sel_b2,
  input  alu_op_e          ex_alu_op_a,
  input  alu_op_e          ex_alu_op_b,
  output logic [`XLEN-1:0] alu_result_a,
  output logic [`XLEN-1:0] alu_result_b
);

  logic [`XLEN-1:0] op_a1;
  logic [`XLEN-1:0] op_a2;
  logic [`XLEN-1:0] op_b1;
  logic [`XLEN-1:0] op_b2;

  function automatic logic [`XLEN-1:0] pick_operand(input src_sel_e sel,
                                                    input logic [`XLEN-1:0] reg_val,
                                                    input logic [`XLEN-1:0] imm,
                                                    input logic [`XLEN-1:0] pc);
    case (sel)
      SRC_IMM:  pick_operand = imm;
      SRC_PC:   pick_operand = pc;
      SRC_FOUR: pick_operand = `XLEN'd4;                    // For bl/jirl link
      default:  pick_operand = reg_val;
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] alu(input alu_op_e op,
                                           input logic [`XLEN-1:0] a,
                                           input logic [`XLEN-1:0] b,
                                           input logic [`XLEN-1:0] imm);
    case (op)
      ALU_ADD:   alu = a + b;
      ALU_SUB:   alu = a - b;
      ALU_SLT:   alu = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU:  alu = {{(`XLEN-1){1'b0}}, a < b};
      ALU_AND:   alu = a & b;
      ALU_OR:    alu = a | b;
      ALU_NOR:   alu = ~(a | b);
      ALU_XOR:   alu = a ^ b;
      ALU_SLL:   alu = a << b[4:0];                         // Shift amount is 5 bits
      ALU_SRL:   alu = a >> b[4:0];
      ALU_SRA:   alu = $signed(a) >>> b[4:0];
      ALU_LU12I: alu = imm;                                 // Already shifted at decode
      default:   alu = '0;
    endcase
  endfunction

  assign op_a1 = pick_operand(ex_src_sel_a1, fwd_a1, ex_imm_a, ex_pc_a);
  assign op_a2 = pick_operand(ex_src_sel_a2, fwd_a2, ex_imm_a, ex_pc_a);
  assign op_b1 = pick_operand(ex_src_sel_b1, fwd_b1, ex_imm_b, ex_pc_b);
  assign op_b2 = pick_operand(ex_src_sel_b2, fwd_b2, ex_imm_b, ex_pc_b);

  assign alu_result_a = alu(ex_alu_op_a, op_a1, op_a2, ex_imm_a);
  assign alu_result_b = alu(ex_alu_op_b, op_b1, op_b2, ex_imm_b);

endmodule

/* source/backend_cfg.svh */
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// Core-wide widths of the LA32 back end

`define XLEN     32              // Data and PC width
`define RADDR_W  5               // Register address width
`define DMEM_AW  12              // Data RAM word address bits

// Boot address of the core
`define RESET_PC 32'h1c00_0000

`endif

/* source/branch_resolve.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module branch_resolve import la32_isa_pkg::*; (
  input  logic [`XLEN-1:0] ex_pc_a,
  input  logic [`XLEN-1:0] ex_pc_b,
  input  logic [`XLEN-1:0] fwd_a1,
  input  logic [`XLEN-1:0] fwd_a2,
  input  logic [`XLEN-1:0] fwd_b1,
  input  logic [`XLEN-1:0] fwd_b2,
  input  logic [`XLEN-1:0] ex_imm_a,
  input  logic [`XLEN-1:0] ex_imm_b,
  input  br_type_e         ex_br_type_a,
  input  br_type_e         ex_br_type_b,
  input  logic             ex_br_pd_a,
  input  logic             ex_br_pd_b,
  output logic             br_redirect,
  output logic [`XLEN-1:0] br_target,
  output logic             squash_b
);

  logic             taken_a;
  logic             taken_b;
  logic [`XLEN-1:0] target_a;
  logic [`XLEN-1:0] target_b;
  logic             mispred_a;
  logic             mispred_b;

  function automatic logic br_taken(input br_type_e bt,
                                    input logic [`XLEN-1:0] rs1,
                                    input logic [`XLEN-1:0] rs2);
    case (bt)
      BR_BEQ:               br_taken = rs1 == rs2;
      BR_BNE:               br_taken = rs1 != rs2;
      BR_BLT:               br_taken = $signed(rs1) < $signed(rs2);
      BR_BGE:               br_taken = $signed(rs1) >= $signed(rs2);
      BR_BLTU:              br_taken = rs1 < rs2;
      BR_BGEU:              br_taken = rs1 >= rs2;
      BR_B, BR_BL, BR_JIRL: br_taken = 1'b1;                // Unconditional
      default:              br_taken = 1'b0;
    endcase
  endfunction

  // Correct next PC of a lane
  function automatic logic [`XLEN-1:0] br_dest(input br_type_e bt,
                                               input logic taken,
                                               input logic [`XLEN-1:0] pc,
                                               input logic [`XLEN-1:0] rs1,
                                               input logic [`XLEN-1:0] imm);
    if (!taken)
      br_dest = pc + `XLEN'd4;
    else if (bt == BR_JIRL)
      br_dest = rs1 + imm;
    else
      br_dest = pc + imm;
  endfunction

  assign taken_a   = br_taken(ex_br_type_a, fwd_a1, fwd_a2);
  assign taken_b   = br_taken(ex_br_type_b, fwd_b1, fwd_b2);
  assign target_a  = br_dest(ex_br_type_a, taken_a, ex_pc_a, fwd_a1, ex_imm_a);
  assign target_b  = br_dest(ex_br_type_b, taken_b, ex_pc_b, fwd_b1, ex_imm_b);
  assign mispred_a = taken_a != ex_br_pd_a;
  assign mispred_b = taken_b != ex_br_pd_b;

  assign br_redirect = mispred_a | mispred_b;
  assign br_target   = mispred_a ? target_a : target_b;     // Older lane first
  assign squash_b    = mispred_a;

endmodule

/* source/ex_mem_wb.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module ex_mem_wb import la32_isa_pkg::*, issue_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [`XLEN-1:0]    ex_pc_a, ex_pc_b,
  input  logic [`XLEN-1:0]    ex_rdata_a1, ex_rdata_a2, ex_rdata_b1, ex_rdata_b2,
  input  logic [`RADDR_W-1:0] ex_raddr_a1, ex_raddr_a2, ex_raddr_b1, ex_raddr_b2,
  input  logic [`XLEN-1:0]    ex_imm_a, ex_imm_b,
  input  src_sel_e            ex_src_sel_a1, ex_src_sel_a2,
  input  src_sel_e            ex_src_sel_b1, ex_src_sel_b2,
  input  alu_op_e             ex_alu_op_a, ex_alu_op_b,
  input  br_type_e            ex_br_type_a, ex_br_type_b,
  input  logic                ex_br_pd_a, ex_br_pd_b,           // 1 means predicted taken
  input  logic                ex_rf_we_a, ex_rf_we_b,
  input  logic [`RADDR_W-1:0] ex_rf_waddr_a, ex_rf_waddr_b,
  input  mem_type_e           ex_mem_type_a, ex_mem_type_b,
  output logic                br_redirect,
  output logic [`XLEN-1:0]    br_target,
  output logic                wb_rf_we_a, wb_rf_we_b,
  output logic [`RADDR_W-1:0] wb_rf_waddr_a, wb_rf_waddr_b,
  output logic [`XLEN-1:0]    wb_rf_wdata_a, wb_rf_wdata_b
);

  logic [`XLEN-1:0]    fwd_a1;                              // Bypassed operands
  logic [`XLEN-1:0]    fwd_a2;
  logic [`XLEN-1:0]    fwd_b1;
  logic [`XLEN-1:0]    fwd_b2;
  logic [`XLEN-1:0]    alu_result_a;
  logic [`XLEN-1:0]    alu_result_b;
  logic                squash_b;
  logic                mem_rf_we_a;
  logic                mem_rf_we_b;
  logic [`RADDR_W-1:0] mem_rf_waddr_a;
  logic [`RADDR_W-1:0] mem_rf_waddr_b;
  logic [`XLEN-1:0]    mem_alu_result_a;
  logic [`XLEN-1:0]    mem_alu_result_b;
  mem_type_e           mem_mem_type_a;
  mem_type_e           mem_mem_type_b;
  logic [`XLEN-1:0]    mem_wdata_a;                         // MEM writeback select
  logic [`XLEN-1:0]    mem_wdata_b;

  operand_forward u_operand_forward (.*);
  alu_pair        u_alu_pair        (.*);
  branch_resolve  u_branch_resolve  (.*);
  mem_port        u_mem_port        (.*);
  stage_regs      u_stage_regs      (.*);

endmodule

/* source/issue_pkg.sv */
package issue_pkg;

  // ALU operand source chosen at issue
  typedef enum logic [1:0] {
    SRC_REG,
    SRC_IMM,
    SRC_PC,
    SRC_FOUR                  // Constant 4 for link values
  } src_sel_e;

  // Where a forwarded EX operand comes from
  typedef enum logic [2:0] {
    FWD_RF,
    FWD_MEM_A,
    FWD_MEM_B,
    FWD_WB_A,
    FWD_WB_B
  } fwd_src_e;

endpackage

/* source/la32_isa_pkg.sv */
package la32_isa_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_OR,
    ALU_NOR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LU12I                 // Immediate pass-through
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_B,
    BR_BL,                    // Link via ALU as pc+4
    BR_JIRL                   // Target is rs1+imm
  } br_type_e;

  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_ST_W,
    MEM_ST_H,
    MEM_ST_B,
    MEM_LD_W,
    MEM_LD_H,
    MEM_LD_HU,
    MEM_LD_B,
    MEM_LD_BU
  } mem_type_e;

endpackage

/* source/mem_port.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module mem_port import la32_isa_pkg::*; (
  input  logic             clk,
  input  mem_type_e        ex_mem_type_a,
  input  mem_type_e        ex_mem_type_b,
  input  logic             squash_b,
  input  logic [`XLEN-1:0] alu_result_a,
  input  logic [`XLEN-1:0] alu_result_b,
  input  logic [`XLEN-1:0] fwd_a2,
  input  logic [`XLEN-1:0] fwd_b2,
  input  mem_type_e        mem_mem_type_a,
  input  mem_type_e        mem_mem_type_b,
  input  logic [`XLEN-1:0] mem_alu_result_a,
  input  logic [`XLEN-1:0] mem_alu_result_b,
  output logic [`XLEN-1:0] mem_wdata_a,
  output logic [`XLEN-1:0] mem_wdata_b
);

  mem_type_e             ex_type;
  logic [`XLEN-1:0]      ex_addr;
  logic [`XLEN-1:0]      st_src;
  logic [3:0]            st_be;
  logic [`XLEN-1:0]      st_data;
  logic [`DMEM_AW-1:0]   word_addr;
  logic [`XLEN-1:0]      rd_word;
  logic [`XLEN-1:0]      dmem [2**`DMEM_AW];

  // At most one memory lane per pair
  always_comb begin
    if (ex_mem_type_a != MEM_NONE) begin
      ex_type = ex_mem_type_a;
      ex_addr = alu_result_a;
      st_src  = fwd_a2;
    end else begin
      ex_type = squash_b ? MEM_NONE : ex_mem_type_b;      // Wrong-path store dropped
      ex_addr = alu_result_b;
      st_src  = fwd_b2;
    end
  end

  always_comb begin
    st_be   = 4'b0000;
    st_data = st_src;
    case (ex_type)
      MEM_ST_B: begin
        st_be   = 4'b0001 << ex_addr[1:0];                  // Little-endian lanes
        st_data = st_src << {ex_addr[1:0], 3'b000};
      end
      MEM_ST_H: begin
        if (!ex_addr[0]) begin
          st_be   = ex_addr[1] ? 4'b1100 : 4'b0011;
          st_data = st_src << {ex_addr[1], 4'b0000};
        end
      end
      MEM_ST_W: begin
        if (ex_addr[1:0] == 2'b00)
          st_be = 4'b1111;
      end
      default: ;
    endcase
  end

  assign word_addr = ex_addr[`DMEM_AW+1:2];

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (st_be[i])
        dmem[word_addr][i*8 +: 8] <= st_data[i*8 +: 8];
    end
    rd_word <= dmem[word_addr];                             // Valid in MEM cycle
  end

  // Load extraction, other lanes keep their ALU result
  function automatic logic [`XLEN-1:0] mem_result(input mem_type_e mtype,
                                                  input logic [`XLEN-1:0] alu_res,
                                                  input logic [`XLEN-1:0] word);
    logic [7:0]  byte_val;
    logic [15:0] half_val;
    byte_val = word[{alu_res[1:0], 3'b000} +: 8];
    half_val = alu_res[1] ? word[31:16] : word[15:0];
    case (mtype)
      MEM_LD_W:  mem_result = word;
      MEM_LD_B:  mem_result = {{(`XLEN-8){byte_val[7]}}, byte_val};
      MEM_LD_BU: mem_result = {{(`XLEN-8){1'b0}}, byte_val};
      MEM_LD_H:  mem_result = alu_res[0] ? word : {{(`XLEN-16){half_val[15]}}, half_val};
      MEM_LD_HU: mem_result = alu_res[0] ? word : {{(`XLEN-16){1'b0}}, half_val};
      default:   mem_result = alu_res;
    endcase
  endfunction

  assign mem_wdata_a = mem_result(mem_mem_type_a, mem_alu_result_a, rd_word);
  assign mem_wdata_b = mem_result(mem_mem_type_b, mem_alu_result_b, rd_word);

endmodule

/* source/operand_forward.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module operand_forward import issue_pkg::*; (
  input  logic [`RADDR_W-1:0] ex_raddr_a1,
  input  logic [`RADDR_W-1:0] ex_raddr_a2,
  input  logic [`RADDR_W-1:0] ex_raddr_b1,
  input  logic [`RADDR_W-1:0] ex_raddr_b2,
  input  logic [`XLEN-1:0]    ex_rdata_a1,
  input  logic [`XLEN-1:0]    ex_rdata_a2,
  input  logic [`XLEN-1:0]    ex_rdata_b1,
  input  logic [`XLEN-1:0]    ex_rdata_b2,
  input  logic                mem_rf_we_a,
  input  logic                mem_rf_we_b,
  input  logic [`RADDR_W-1:0] mem_rf_waddr_a,
  input  logic [`RADDR_W-1:0] mem_rf_waddr_b,
  input  logic [`XLEN-1:0]    mem_alu_result_a,
  input  logic [`XLEN-1:0]    mem_alu_result_b,
  input  logic                wb_rf_we_a,
  input  logic                wb_rf_we_b,
  input  logic [`RADDR_W-1:0] wb_rf_waddr_a,
  input  logic [`RADDR_W-1:0] wb_rf_waddr_b,
  input  logic [`XLEN-1:0]    wb_rf_wdata_a,
  input  logic [`XLEN-1:0]    wb_rf_wdata_b,
  output logic [`XLEN-1:0]    fwd_a1,
  output logic [`XLEN-1:0]    fwd_a2,
  output logic [`XLEN-1:0]    fwd_b1,
  output logic [`XLEN-1:0]    fwd_b2
);

  fwd_src_e sel_a1;
  fwd_src_e sel_a2;
  fwd_src_e sel_b1;
  fwd_src_e sel_b2;

  // Younger lane and nearer stage win
  function automatic fwd_src_e pick_src(input logic [`RADDR_W-1:0] raddr);
    pick_src = FWD_RF;
    if (raddr != '0) begin                                  // r0 is hardwired
      if (mem_rf_we_b && mem_rf_waddr_b == raddr)
        pick_src = FWD_MEM_B;
      else if (mem_rf_we_a && mem_rf_waddr_a == raddr)
        pick_src = FWD_MEM_A;
      else if (wb_rf_we_b && wb_rf_waddr_b == raddr)
        pick_src = FWD_WB_B;
      else if (wb_rf_we_a && wb_rf_waddr_a == raddr)
        pick_src = FWD_WB_A;
    end
  endfunction

  function automatic logic [`XLEN-1:0] mux_src(input fwd_src_e sel,
                                               input logic [`XLEN-1:0] rf_val);
    case (sel)
      FWD_MEM_B: mux_src = mem_alu_result_b;                // ALU results only
      FWD_MEM_A: mux_src = mem_alu_result_a;
      FWD_WB_B:  mux_src = wb_rf_wdata_b;
      FWD_WB_A:  mux_src = wb_rf_wdata_a;
      default:   mux_src = rf_val;
    endcase
  endfunction

  always_comb begin
    sel_a1 = pick_src(ex_raddr_a1);
    sel_a2 = pick_src(ex_raddr_a2);
    sel_b1 = pick_src(ex_raddr_b1);
    sel_b2 = pick_src(ex_raddr_b2);
    fwd_a1 = mux_src(sel_a1, ex_rdata_a1);
    fwd_a2 = mux_src(sel_a2, ex_rdata_a2);
    fwd_b1 = mux_src(sel_b1, ex_rdata_b1);
    fwd_b2 = mux_src(sel_b2, ex_rdata_b2);
  end

endmodule

/* source/stage_regs.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module stage_regs import la32_isa_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                squash_b,
  input  logic [`XLEN-1:0]    alu_result_a,
  input  logic [`XLEN-1:0]    alu_result_b,
  input  logic                ex_rf_we_a,
  input  logic                ex_rf_we_b,
  input  logic [`RADDR_W-1:0] ex_rf_waddr_a,
  input  logic [`RADDR_W-1:0] ex_rf_waddr_b,
  input  mem_type_e           ex_mem_type_a,
  input  mem_type_e           ex_mem_type_b,
  input  logic [`XLEN-1:0]    mem_wdata_a,
  input  logic [`XLEN-1:0]    mem_wdata_b,
  output logic                mem_rf_we_a,
  output logic                mem_rf_we_b,
  output logic [`RADDR_W-1:0] mem_rf_waddr_a,
  output logic [`RADDR_W-1:0] mem_rf_waddr_b,
  output logic [`XLEN-1:0]    mem_alu_result_a,
  output logic [`XLEN-1:0]    mem_alu_result_b,
  output mem_type_e           mem_mem_type_a,
  output mem_type_e           mem_mem_type_b,
  output logic                wb_rf_we_a,
  output logic                wb_rf_we_b,
  output logic [`RADDR_W-1:0] wb_rf_waddr_a,
  output logic [`RADDR_W-1:0] wb_rf_waddr_b,
  output logic [`XLEN-1:0]    wb_rf_wdata_a,
  output logic [`XLEN-1:0]    wb_rf_wdata_b
);

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_rf_we_a    <= 1'b0;
      mem_rf_we_b    <= 1'b0;
      mem_mem_type_a <= MEM_NONE;
      mem_mem_type_b <= MEM_NONE;
      wb_rf_we_a     <= 1'b0;
      wb_rf_we_b     <= 1'b0;
    end else begin
      mem_rf_we_a    <= ex_rf_we_a;
      mem_rf_we_b    <= ex_rf_we_b & ~squash_b;            // Kill B behind A mispredict
      mem_mem_type_a <= ex_mem_type_a;
      mem_mem_type_b <= squash_b ? MEM_NONE : ex_mem_type_b;
      wb_rf_we_a     <= mem_rf_we_a;
      wb_rf_we_b     <= mem_rf_we_b;
    end
  end

  always_ff @(posedge clk) begin
    mem_rf_waddr_a   <= ex_rf_waddr_a;
    mem_rf_waddr_b   <= ex_rf_waddr_b;
    mem_alu_result_a <= alu_result_a;
    mem_alu_result_b <= alu_result_b;
    wb_rf_waddr_a    <= mem_rf_waddr_a;
    wb_rf_waddr_b    <= mem_rf_waddr_b;
    wb_rf_wdata_a    <= mem_wdata_a;                        // Load data or ALU result
    wb_rf_wdata_b    <= mem_wdata_b;
  end

endmodule

/* verif/ex_mem_wb_assertions.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module ex_mem_wb_assertions import la32_isa_pkg::*, issue_pkg::*; (
  input logic                clk,
  input logic                rst,
  input logic                wb_rf_we_a,
  input logic                wb_rf_we_b,
  input logic                squash_b,
  input logic                br_redirect,
  input logic                mem_rf_we_b,
  input mem_type_e           mem_mem_type_b,
  input logic [`RADDR_W-1:0] ex_raddr_a1,
  input logic [`RADDR_W-1:0] ex_raddr_a2,
  input logic [`RADDR_W-1:0] ex_raddr_b1,
  input logic [`RADDR_W-1:0] ex_raddr_b2,
  input fwd_src_e            sel_a1,
  input fwd_src_e            sel_a2,
  input fwd_src_e            sel_b1,
  input fwd_src_e            sel_b2
);

  int fail_count = 0;

  // r0 reads always come from the register file
  property no_r0_fwd(raddr, sel);
    @(posedge clk) disable iff (rst) (raddr == '0) |-> (sel == FWD_RF);
  endproperty

  we_low_after_reset: assert property (@(posedge clk) rst |=> (!wb_rf_we_a && !wb_rf_we_b))
    else begin
      $error("WB write enable high after reset");
      fail_count++;
    end

  // A squash comes with a redirect and kills lane B on entry to MEM
  squash_needs_redirect: assert property (@(posedge clk) disable iff (rst)
                                          squash_b |-> br_redirect ##1
                                          (!mem_rf_we_b && mem_mem_type_b == MEM_NONE))
    else begin
      $error("squash_b without br_redirect or lane B not killed");
      fail_count++;
    end

  r0_a1: assert property (no_r0_fwd(ex_raddr_a1, sel_a1))
    else begin
      $error("r0 forwarded on a1");
      fail_count++;
    end
  r0_a2: assert property (no_r0_fwd(ex_raddr_a2, sel_a2))
    else begin
      $error("r0 forwarded on a2");
      fail_count++;
    end
  r0_b1: assert property (no_r0_fwd(ex_raddr_b1, sel_b1))
    else begin
      $error("r0 forwarded on b1");
      fail_count++;
    end
  r0_b2: assert property (no_r0_fwd(ex_raddr_b2, sel_b2))
    else begin
      $error("r0 forwarded on b2");
      fail_count++;
    end

endmodule

bind ex_mem_wb ex_mem_wb_assertions u_assertions (
  .clk(clk), .rst(rst), .wb_rf_we_a(wb_rf_we_a), .wb_rf_we_b(wb_rf_we_b),
  .squash_b(squash_b), .br_redirect(br_redirect),
  .mem_rf_we_b(mem_rf_we_b), .mem_mem_type_b(mem_mem_type_b),
  .ex_raddr_a1(ex_raddr_a1), .ex_raddr_a2(ex_raddr_a2),
  .ex_raddr_b1(ex_raddr_b1), .ex_raddr_b2(ex_raddr_b2),
  .sel_a1(u_operand_forward.sel_a1), .sel_a2(u_operand_forward.sel_a2),
  .sel_b1(u_operand_forward.sel_b1), .sel_b2(u_operand_forward.sel_b2)
);

/* verif/tb_ex_mem_wb.sv */
`timescale 1ns/1ps
`include "backend_cfg.svh"

module tb_ex_mem_wb import la32_isa_pkg::*, issue_pkg::*; ();

  localparam int               NUM_PAIRS      = 200;
  localparam int               TIMEOUT_CYCLES = 50;
  localparam logic [`XLEN-1:0] DATA_BASE      = 32'h0000_0100;  // Eight words under test

  typedef struct packed {
    logic [`XLEN-1:0]    pc;
    logic [`XLEN-1:0]    rdata1;
    logic [`XLEN-1:0]    rdata2;
    logic [`XLEN-1:0]    imm;
    logic [`RADDR_W-1:0] raddr1;
    logic [`RADDR_W-1:0] raddr2;
    src_sel_e            sel1;
    src_sel_e            sel2;
    alu_op_e             op;
    br_type_e            br;
    logic                pd;
    logic                we;
    logic [`RADDR_W-1:0] waddr;
    mem_type_e           mt;
    logic                exp_we;                            // After squash
    logic [`XLEN-1:0]    exp_wdata;
  } lane_t;

  logic                clk;
  logic                rst;
  logic [`XLEN-1:0]    ex_pc_a, ex_pc_b, ex_imm_a, ex_imm_b;
  logic [`XLEN-1:0]    ex_rdata_a1, ex_rdata_a2, ex_rdata_b1, ex_rdata_b2;
  logic [`RADDR_W-1:0] ex_raddr_a1, ex_raddr_a2, ex_raddr_b1, ex_raddr_b2;
  src_sel_e            ex_src_sel_a1, ex_src_sel_a2, ex_src_sel_b1, ex_src_sel_b2;
  alu_op_e             ex_alu_op_a, ex_alu_op_b;
  br_type_e            ex_br_type_a, ex_br_type_b;
  logic                ex_br_pd_a, ex_br_pd_b, ex_rf_we_a, ex_rf_we_b;
  logic [`RADDR_W-1:0] ex_rf_waddr_a, ex_rf_waddr_b;
  mem_type_e           ex_mem_type_a, ex_mem_type_b;
  logic                br_redirect;
  logic [`XLEN-1:0]    br_target;
  logic                wb_rf_we_a, wb_rf_we_b;
  logic [`RADDR_W-1:0] wb_rf_waddr_a, wb_rf_waddr_b;
  logic [`XLEN-1:0]    wb_rf_wdata_a, wb_rf_wdata_b;

  lane_t            tab_a [NUM_PAIRS];
  lane_t            tab_b [NUM_PAIRS];
  logic             exp_redirect [NUM_PAIRS];
  logic [`XLEN-1:0] exp_target [NUM_PAIRS];
  logic [`XLEN-1:0] rf [32];                                // Architectural state
  logic [`XLEN-1:0] rf_d1 [32];                             // One pair behind
  logic [`XLEN-1:0] rf_d2 [32];                             // Contents seen at EX read
  logic [7:0]       ram [32];                               // Bytes of the data window
  logic [31:0]      load_mask;                              // Load-use registers to avoid
  logic [31:0]      lfsr;
  int               errors;
  int               checks;

  ex_mem_wb dut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic signed_lt(input logic [31:0] x, input logic [31:0] y);
    return (x[31] != y[31]) ? x[31] : (x < y);
  endfunction

  function automatic logic [31:0] operand(input src_sel_e sel, input logic [31:0] regv,
                                          input logic [31:0] imm, input logic [31:0] pc);
    case (sel)
      SRC_REG: return regv;
      SRC_IMM: return imm;
      SRC_PC:  return pc;
      default: return 32'd4;
    endcase
  endfunction

  function automatic logic [31:0] alu_ref(input alu_op_e op, input logic [31:0] x,
                                          input logic [31:0] y, input logic [31:0] imm);
    logic [31:0] r;
    case (op)
      ALU_ADD:   r = x + y;
      ALU_SUB:   r = x + ~y + 32'd1;
      ALU_SLT:   r = {31'b0, signed_lt(x, y)};
      ALU_SLTU:  r = (x < y) ? 32'd1 : 32'd0;
      ALU_AND:   r = x & y;
      ALU_OR:    r = x | y;
      ALU_NOR:   r = ~x & ~y;
      ALU_XOR:   r = x ^ y;
      ALU_SLL:   r = x << y[4:0];
      ALU_SRL:   r = x >> y[4:0];
      ALU_SRA: begin
        r = x >> y[4:0];
        if (x[31])
          r = r | ~(32'hffff_ffff >> y[4:0]);               // Fill with sign
      end
      ALU_LU12I: r = imm;
      default:   r = '0;
    endcase
    return r;
  endfunction

  function automatic logic taken_ref(input br_type_e br, input logic [31:0] x,
                                     input logic [31:0] y);
    case (br)
      BR_BEQ:               return x == y;
      BR_BNE:               return x != y;
      BR_BLT:               return signed_lt(x, y);
      BR_BGE:               return !signed_lt(x, y);
      BR_BLTU:              return x < y;
      BR_BGEU:              return !(x < y);
      BR_B, BR_BL, BR_JIRL: return 1'b1;
      default:              return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] next_pc(input lane_t l, input logic tk, input logic [31:0] v1);
    if (!tk)
      return l.pc + 32'd4;
    return (l.br == BR_JIRL) ? v1 + l.imm : l.pc + l.imm;
  endfunction

  function automatic logic [4:0] pick_reg(input logic [31:0] avoid);
    logic [4:0] r;
    r = 5'(rnd(3));                                         // Few registers, many hazards
    return avoid[r] ? 5'd0 : r;
  endfunction

  task automatic make_lane(output lane_t l, input logic is_mem, input logic [31:0] pc,
                           input logic [31:0] avoid);
    l        = '0;
    l.pc     = pc;
    l.raddr1 = pick_reg(avoid);
    l.raddr2 = pick_reg(avoid);
    l.waddr  = 5'(rnd(3));
    l.sel1   = src_sel_e'(2'(rnd(2)));
    l.sel2   = src_sel_e'(2'(rnd(2)));
    l.imm    = rnd(32);
    l.op     = alu_op_e'(4'(rnd(4) % 12));
    l.we     = 1'b1;
    if (is_mem) begin
      l.mt     = mem_type_e'(4'(rnd(3) + 1));
      l.raddr1 = '0;                                        // r0 base, address is the imm
      l.sel1   = SRC_REG;
      l.sel2   = SRC_IMM;
      l.op     = ALU_ADD;
      l.imm    = DATA_BASE + rnd(5);
      case (l.mt)
        MEM_ST_W, MEM_LD_W:            l.imm[1:0] = 2'b00;
        MEM_ST_H, MEM_LD_H, MEM_LD_HU: l.imm[0] = 1'b0;
        default: ;
      endcase
      l.we = l.mt >= MEM_LD_W;
    end else if (rnd(2) == 0) begin
      l.br  = br_type_e'(4'(rnd(4) % 9 + 1));
      l.imm = rnd(8) << 2;
      l.pd  = rnd(1);
      l.we  = l.br == BR_BL || l.br == BR_JIRL;
      if (l.we) begin
        l.sel1 = SRC_PC;                                    // Link value pc+4
        l.sel2 = SRC_FOUR;
        l.op   = ALU_ADD;
      end
    end
  endtask

  task automatic write_bytes(input logic [4:0] idx, input logic [31:0] data, input int n);
    for (int i = 0; i < n; i++)
      ram[idx + i] = data[8*i +: 8];                        // Little-endian
  endtask

  task automatic exec_lane(inout lane_t l, input logic [31:0] v1, input logic [31:0] v2,
                           input logic kill);
    logic [31:0] res;
    logic [4:0]  idx;
    res = alu_ref(l.op, operand(l.sel1, v1, l.imm, l.pc), operand(l.sel2, v2, l.imm, l.pc),
                  l.imm);
    idx = res[4:0];
    case (l.mt)
      MEM_ST_W:  if (!kill) write_bytes(idx, v2, 4);
      MEM_ST_H:  if (!kill) write_bytes(idx, v2, 2);
      MEM_ST_B:  if (!kill) write_bytes(idx, v2, 1);
      MEM_LD_W:  res = {ram[idx + 3], ram[idx + 2], ram[idx + 1], ram[idx]};
      MEM_LD_H:  res = {{16{ram[idx + 1][7]}}, ram[idx + 1], ram[idx]};
      MEM_LD_HU: res = {16'h0, ram[idx + 1], ram[idx]};
      MEM_LD_B:  res = {{24{ram[idx][7]}}, ram[idx]};
      MEM_LD_BU: res = {24'h0, ram[idx]};
      default: ;
    endcase
    l.exp_we    = l.we & ~kill;
    l.exp_wdata = res;
    if (l.exp_we && l.waddr != '0)
      rf[l.waddr] = res;
  endtask

  task automatic build_table();
    lane_t       a;
    lane_t       b;
    logic [31:0] va1, va2, vb1, vb2, avoid;
    logic [31:0] pc;
    logic [1:0]  mem_sel;
    logic        tk_a, tk_b, mp_a, mp_b;
    pc    = `RESET_PC;
    rf[0] = '0;
    for (int i = 1; i < 32; i++)
      rf[i] = rnd(32);
    rf_d1     = rf;
    rf_d2     = rf;
    load_mask = '0;
    for (int k = 0; k < NUM_PAIRS; k++) begin
      mem_sel = (k < 8) ? 2'd1 : 2'(rnd(2));
      make_lane(a, mem_sel == 2'd1, pc, load_mask);
      if (k < 8) begin                                      // Fill the data window first
        a.mt  = MEM_ST_W;
        a.imm = DATA_BASE + 32'(k * 4);
        a.we  = 1'b0;
      end
      avoid = load_mask;
      if (a.we)
        avoid[a.waddr] = 1'b1;                              // No dependency inside a pair
      make_lane(b, mem_sel == 2'd2, pc + 32'd4, avoid);
      a.rdata1 = rf_d2[a.raddr1];
      a.rdata2 = rf_d2[a.raddr2];
      b.rdata1 = rf_d2[b.raddr1];
      b.rdata2 = rf_d2[b.raddr2];
      va1 = rf[a.raddr1];
      va2 = rf[a.raddr2];
      vb1 = rf[b.raddr1];
      vb2 = rf[b.raddr2];
      tk_a = taken_ref(a.br, va1, va2);
      tk_b = taken_ref(b.br, vb1, vb2);
      mp_a = tk_a != a.pd;
      mp_b = tk_b != b.pd;
      exp_redirect[k] = mp_a | mp_b;
      exp_target[k]   = mp_a ? next_pc(a, tk_a, va1) : next_pc(b, tk_b, vb1);
      rf_d2 = rf_d1;
      rf_d1 = rf;
      exec_lane(a, va1, va2, 1'b0);
      exec_lane(b, vb1, vb2, mp_a);                         // B dies behind A mispredict
      load_mask = '0;
      if (a.exp_we && a.mt >= MEM_LD_W)
        load_mask[a.waddr] = 1'b1;
      if (b.exp_we && b.mt >= MEM_LD_W)
        load_mask[b.waddr] = 1'b1;
      tab_a[k] = a;
      tab_b[k] = b;
      pc       = pc + 32'd8;
    end
  endtask

  task automatic drive_pair(input lane_t a, input lane_t b);
    ex_pc_a       = a.pc;
    ex_rdata_a1   = a.rdata1;
    ex_rdata_a2   = a.rdata2;
    ex_raddr_a1   = a.raddr1;
    ex_raddr_a2   = a.raddr2;
    ex_imm_a      = a.imm;
    ex_src_sel_a1 = a.sel1;
    ex_src_sel_a2 = a.sel2;
    ex_alu_op_a   = a.op;
    ex_br_type_a  = a.br;
    ex_br_pd_a    = a.pd;
    ex_rf_we_a    = a.we;
    ex_rf_waddr_a = a.waddr;
    ex_mem_type_a = a.mt;
    ex_pc_b       = b.pc;
    ex_rdata_b1   = b.rdata1;
    ex_rdata_b2   = b.rdata2;
    ex_raddr_b1   = b.raddr1;
    ex_raddr_b2   = b.raddr2;
    ex_imm_b      = b.imm;
    ex_src_sel_b1 = b.sel1;
    ex_src_sel_b2 = b.sel2;
    ex_alu_op_b   = b.op;
    ex_br_type_b  = b.br;
    ex_br_pd_b    = b.pd;
    ex_rf_we_b    = b.we;
    ex_rf_waddr_b = b.waddr;
    ex_mem_type_b = b.mt;
  endtask

  task automatic check_port(input int k, input string lane, input logic we,
                            input logic [4:0] waddr, input logic [31:0] wdata, input lane_t e);
    checks++;
    if (we !== e.exp_we) begin
      errors++;
      $display("ERR %0t pair %0d lane %s: write enable %b, expected %b",
               $time, k, lane, we, e.exp_we);
    end else if (e.exp_we && (waddr !== e.waddr || wdata !== e.exp_wdata)) begin
      errors++;
      $display("ERR %0t pair %0d lane %s: wrote r%0d=%h, expected r%0d=%h",
               $time, k, lane, waddr, wdata, e.waddr, e.exp_wdata);
    end
  endtask

  task automatic check_branch(input int k);
    checks++;
    if (br_redirect !== exp_redirect[k] ||
        (exp_redirect[k] && br_target !== exp_target[k])) begin
      errors++;
      $display("ERR %0t pair %0d: redirect %b target %h, expected %b target %h",
               $time, k, br_redirect, br_target, exp_redirect[k], exp_target[k]);
    end
  endtask

  task automatic run_table(input lane_t idle);
    for (int c = 0; c < NUM_PAIRS + 2; c++) begin
      @(negedge clk);
      if (c >= 2) begin                                     // Pair c-2 has reached WB
        check_port(c - 2, "A", wb_rf_we_a, wb_rf_waddr_a, wb_rf_wdata_a, tab_a[c - 2]);
        check_port(c - 2, "B", wb_rf_we_b, wb_rf_waddr_b, wb_rf_wdata_b, tab_b[c - 2]);
      end
      if (c < NUM_PAIRS) begin
        drive_pair(tab_a[c], tab_b[c]);
        #5;
        check_branch(c);
      end else begin
        drive_pair(idle, idle);
      end
    end
  endtask

  initial begin
    lane_t idle;
    int    wait_cnt;
    idle   = '0;
    clk    = 1'b0;
    rst    = 1'b1;
    errors = 0;
    checks = 0;
    lfsr   = 32'h2344;
    drive_pair(idle, idle);
    build_table();
    repeat (10) @(negedge clk);
    rst      = 1'b0;
    wait_cnt = 0;
    while ((wb_rf_we_a !== 1'b0 || wb_rf_we_b !== 1'b0) && wait_cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (wait_cnt >= TIMEOUT_CYCLES) begin
      $display("Timed out waiting for the write enables to clear after reset");
      $display("Finished with errors");
    end else begin
      for (int i = 0; i < 3; i++) begin                     // Idle pipeline stays quiet
        @(negedge clk);
        checks++;
        if (wb_rf_we_a !== 1'b0 || wb_rf_we_b !== 1'b0) begin
          errors++;
          $display("ERR %0t write enable high with no pairs issued", $time);
        end
      end
      run_table(idle);
      errors = errors + dut.u_assertions.fail_count;
      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0)
        $display("Finished with no errors");
      else
        $display("Finished with errors");
    end
    $finish;
  end

endmodule
